// ==== verilog/fetch_predict_defines.svh ====
// ==========================================================
// width, table size, queue depth and slot size macros
// for the two-slot fetch branch predictor
// ==========================================================
`ifndef FETCH_PREDICT_DEFINES_SVH
`define FETCH_PREDICT_DEFINES_SVH

// instruction address width in bits
`define FP_ADDR_W 32

// index bits of the target table, 1 << 10 = 1024 entries
`define FP_INDEX_W 10

// bytes per instruction slot
// slot 1 sits at pc + 5, fall-through at pc + 10
`define FP_SLOT_BYTES 5

// commit queue pointer width, 8 places
// equal pointers mean empty so at most 7 entries are held
`define FP_CQ_PTR_W 3

`endif

// ==== verilog/fetch_predict_pkg.sv ====
// ==========================================================
// shared types of the fetch branch predictor
// addresses, table indexes, commit queue pointers
// ==========================================================
`default_nettype none

`include "fetch_predict_defines.svh"

package fetch_predict_pkg;

  // ==========================================================
  // address types
  // ==========================================================

  // fetch address, branch address and branch target
  typedef logic [`FP_ADDR_W-1:0] addr_t;

  // ==========================================================
  // table and queue types
  // ==========================================================

  // low bits of a branch address, selects one table entry
  typedef logic [`FP_INDEX_W-1:0] btb_index_t;

  // commit queue read / write pointer, wraps naturally
  typedef logic [`FP_CQ_PTR_W-1:0] cq_ptr_t;

endpackage

`default_nettype wire

// ==== verilog/btb_commit_queue.sv ====
// ==========================================================
// commit queue for taken branches
// takes up to two commits per cycle in slot order and
// drains one table write per cycle from an 8-place ring
// ==========================================================
`default_nettype none

`include "fetch_predict_defines.svh"

module btb_commit_queue (
  input  logic                     rclk,
  input  logic                     rst,
  input  logic                     commit_takb0,  // slot 0 retired a taken branch
  input  fetch_predict_pkg::addr_t commit_pc0,
  input  fetch_predict_pkg::addr_t commit_tgt0,
  input  logic                     commit_takb1,  // slot 1 retired a taken branch
  input  fetch_predict_pkg::addr_t commit_pc1,
  input  fetch_predict_pkg::addr_t commit_tgt1,
  output logic                     wr_en,         // one table write per entry
  output fetch_predict_pkg::addr_t wr_pc,
  output fetch_predict_pkg::addr_t wr_tgt
);

  import fetch_predict_pkg::*;

  localparam int CQ_DEPTH = 1 << `FP_CQ_PTR_W;

  // ==========================================================
  // ring storage and pointers
  // ==========================================================

  addr_t      cq_pc  [CQ_DEPTH];  // branch address per place
  addr_t      cq_tgt [CQ_DEPTH];  // target per place
  cq_ptr_t    wr_ptr;             // next free place
  cq_ptr_t    rd_ptr;             // oldest entry
  cq_ptr_t    occupancy;
  cq_ptr_t    free_cnt;
  cq_ptr_t    slot1_ptr;          // where a slot 1 commit lands
  logic [1:0] push_cnt;           // commits offered this cycle
  logic       accept;
  logic       not_empty;

  assign occupancy = wr_ptr - rd_ptr;
  // one place always stays unused so full and empty differ
  assign free_cnt  = cq_ptr_t'(CQ_DEPTH - 1) - occupancy;
  assign push_cnt  = {1'b0, commit_takb0} + {1'b0, commit_takb1};
  assign accept    = free_cnt >= cq_ptr_t'(push_cnt);  // else whole cycle dropped
  assign not_empty = wr_ptr != rd_ptr;
  // slot 1 goes behind slot 0 when both retire together
  assign slot1_ptr = wr_ptr + cq_ptr_t'(commit_takb0);

  // ==========================================================
  // append
  // ==========================================================

  always_ff @(posedge rclk) begin
    if (accept && commit_takb0) begin
      cq_pc[wr_ptr]  <= commit_pc0;
      cq_tgt[wr_ptr] <= commit_tgt0;
    end
    if (accept && commit_takb1) begin
      cq_pc[slot1_ptr]  <= commit_pc1;
      cq_tgt[slot1_ptr] <= commit_tgt1;
    end
  end

  // ==========================================================
  // pointers and drain strobe
  // ==========================================================

  always_ff @(posedge rclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      wr_en  <= 1'b0;
    end else begin
      if (accept)
        wr_ptr <= wr_ptr + cq_ptr_t'(push_cnt);
      wr_en <= not_empty;                  // oldest entry leaves this edge
      if (not_empty)
        rd_ptr <= rd_ptr + cq_ptr_t'(1);
    end
  end

  // write payload, only meaningful with wr_en
  always_ff @(posedge rclk) begin
    if (not_empty) begin
      wr_pc  <= cq_pc[rd_ptr];
      wr_tgt <= cq_tgt[rd_ptr];
    end
  end

  // ==========================================================
  // assertions
  // ==========================================================

  // places the offered commits need, same-edge drain not counted
  logic [`FP_CQ_PTR_W:0] occ_next;
  // entry count kept apart from the pointers, drains while non-zero
  logic [`FP_CQ_PTR_W:0] shadow_cnt;
  logic [`FP_CQ_PTR_W:0] shadow_pop;

  assign occ_next   = {1'b0, occupancy} + (`FP_CQ_PTR_W + 1)'(push_cnt);
  assign shadow_pop = (`FP_CQ_PTR_W + 1)'(shadow_cnt != '0);

  always_ff @(posedge rclk) begin
    if (rst)
      shadow_cnt <= '0;
    else if (accept)
      shadow_cnt <= shadow_cnt + (`FP_CQ_PTR_W + 1)'(push_cnt) - shadow_pop;
    else
      shadow_cnt <= shadow_cnt - shadow_pop;
  end

  // commit side must never offer more than the queue can hold
  a_occ_bound : assert property (@(posedge rclk) disable iff (rst)
    occ_next <= (`FP_CQ_PTR_W + 1)'(CQ_DEPTH - 1))
    else $error("commit queue overflow, occupancy would reach %0d", occ_next);

  // a table write always carries a real entry
  a_wr_from_entry : assert property (@(posedge rclk) disable iff (rst)
    wr_en |-> $past(shadow_cnt) != '0)
    else $error("table write issued from an empty commit queue");

endmodule

`default_nettype wire

// ==== verilog/btb_table.sv ====
// ==========================================================
// direct-mapped branch target table
// one write port, two registered read ports (slot 0 / 1),
// valid bits cleared by reset
// ==========================================================
`default_nettype none

`include "fetch_predict_defines.svh"

module btb_table (
  input  logic                     rclk,
  input  logic                     rst,
  input  logic                     wr_en,        // from commit queue
  input  fetch_predict_pkg::addr_t wr_pc,
  input  fetch_predict_pkg::addr_t wr_tgt,
  input  logic                     fetch_valid,  // fetch strobe
  input  fetch_predict_pkg::addr_t fetch_pc,
  output logic                     rd_valid,     // read data below belongs to a fetch
  output fetch_predict_pkg::addr_t rd_pc,
  output logic                     rd_vld0,
  output fetch_predict_pkg::addr_t rd_tag0,
  output fetch_predict_pkg::addr_t rd_tgt0,
  output logic                     rd_vld1,
  output fetch_predict_pkg::addr_t rd_tag1,
  output fetch_predict_pkg::addr_t rd_tgt1
);

  import fetch_predict_pkg::*;

  localparam int ENTRIES = 1 << `FP_INDEX_W;

  addr_t              tag_mem [ENTRIES];  // full branch address as tag
  addr_t              tgt_mem [ENTRIES];
  logic [ENTRIES-1:0] valid;

  addr_t      slot1_pc;
  btb_index_t rd_idx0;
  btb_index_t rd_idx1;
  btb_index_t wr_idx;

  assign slot1_pc = fetch_pc + addr_t'(`FP_SLOT_BYTES);  // second slot of the fetch
  assign rd_idx0  = fetch_pc[`FP_INDEX_W-1:0];
  assign rd_idx1  = slot1_pc[`FP_INDEX_W-1:0];
  assign wr_idx   = wr_pc[`FP_INDEX_W-1:0];

  // ==========================================================
  // array write, later write to an index replaces the entry
  // ==========================================================

  always_ff @(posedge rclk) begin
    if (wr_en) begin
      tag_mem[wr_idx] <= wr_pc;
      tgt_mem[wr_idx] <= wr_tgt;
    end
  end

  always_ff @(posedge rclk) begin
    if (rst)
      valid <= '0;          // every fetch misses after reset
    else if (wr_en)
      valid[wr_idx] <= 1'b1;
  end

  // ==========================================================
  // registered reads, same-edge write returns the old entry
  // ==========================================================

  always_ff @(posedge rclk) begin
    if (fetch_valid) begin
      rd_pc   <= fetch_pc;
      rd_vld0 <= valid[rd_idx0];
      rd_tag0 <= tag_mem[rd_idx0];
      rd_tgt0 <= tgt_mem[rd_idx0];
      rd_vld1 <= valid[rd_idx1];
      rd_tag1 <= tag_mem[rd_idx1];
      rd_tgt1 <= tgt_mem[rd_idx1];
    end
  end

  always_ff @(posedge rclk) begin
    if (rst)
      rd_valid <= 1'b0;
    else
      rd_valid <= fetch_valid;
  end

  // write address comes straight from the queue registers
  a_wr_pc_known : assert property (@(posedge rclk) disable iff (rst)
    wr_en |-> !$isunknown(wr_pc))
    else $error("table write with unknown address");

endmodule

`default_nettype wire

// ==== verilog/btb_lookup.sv ====
// ==========================================================
// prediction stage, tag compare for both slots,
// slot 0 priority, fall-through and output register
// ==========================================================
`default_nettype none

`include "fetch_predict_defines.svh"

module btb_lookup (
  input  logic                     rclk,
  input  logic                     rst,
  input  logic                     rd_valid,
  input  fetch_predict_pkg::addr_t rd_pc,      // fetch address of this read
  input  logic                     rd_vld0,
  input  fetch_predict_pkg::addr_t rd_tag0,
  input  fetch_predict_pkg::addr_t rd_tgt0,
  input  logic                     rd_vld1,
  input  fetch_predict_pkg::addr_t rd_tag1,
  input  fetch_predict_pkg::addr_t rd_tgt1,
  output logic                     pred_valid,
  output fetch_predict_pkg::addr_t next_pc,
  output logic                     takb,
  output logic                     takb_slot   // 0 = first slot, 1 = second
);

  import fetch_predict_pkg::*;

  addr_t slot1_pc;    // address of the second slot
  addr_t fall_pc;     // no taken branch, skip both slots
  addr_t sel_pc;
  logic  hit0;
  logic  hit1;
  logic  sel_slot;

  assign slot1_pc = rd_pc + addr_t'(`FP_SLOT_BYTES);
  assign fall_pc  = rd_pc + addr_t'(2 * `FP_SLOT_BYTES);
  assign hit0     = rd_vld0 && (rd_tag0 == rd_pc);
  assign hit1     = rd_vld1 && (rd_tag1 == slot1_pc);

  // ==========================================================
  // choose next fetch address
  // ==========================================================

  always_comb begin
    if (hit0) begin             // first slot wins when both hit
      sel_pc   = rd_tgt0;
      sel_slot = 1'b0;
    end else if (hit1) begin
      sel_pc   = rd_tgt1;
      sel_slot = 1'b1;
    end else begin
      sel_pc   = fall_pc;
      sel_slot = 1'b0;
    end
  end

  // ==========================================================
  // output register
  // ==========================================================

  always_ff @(posedge rclk) begin
    if (rst) begin
      pred_valid <= 1'b0;
      takb       <= 1'b0;
    end else begin
      pred_valid <= rd_valid;
      takb       <= rd_valid && (hit0 || hit1);  // read data stale without a fetch
    end
  end

  always_ff @(posedge rclk) begin
    next_pc   <= sel_pc;
    takb_slot <= sel_slot;
  end

  // a taken prediction belongs to a fetch and carries a stored target
  a_takb_valid : assert property (@(posedge rclk) disable iff (rst)
    takb |-> pred_valid && !$isunknown(next_pc))
    else $error("taken prediction without a valid fetch or a known target");

endmodule

`default_nettype wire

// ==== verilog/fetch_predict.sv ====
// ==========================================================
// fetch branch predictor top
// commit queue, target table and lookup stage
// ==========================================================
`default_nettype none

`include "fetch_predict_defines.svh"

module fetch_predict (
  input  logic                     rclk,
  input  logic                     rst,
  input  logic                     commit_takb0,
  input  fetch_predict_pkg::addr_t commit_pc0,
  input  fetch_predict_pkg::addr_t commit_tgt0,
  input  logic                     commit_takb1,
  input  fetch_predict_pkg::addr_t commit_pc1,
  input  fetch_predict_pkg::addr_t commit_tgt1,
  input  logic                     fetch_valid,
  input  fetch_predict_pkg::addr_t fetch_pc,
  output logic                     pred_valid,   // two edges after fetch_valid
  output fetch_predict_pkg::addr_t next_pc,
  output logic                     takb,
  output logic                     takb_slot
);

  import fetch_predict_pkg::*;

  // queue to table
  logic  wr_en;
  addr_t wr_pc;
  addr_t wr_tgt;

  // table to lookup
  logic  rd_valid;
  addr_t rd_pc;
  logic  rd_vld0;
  addr_t rd_tag0;
  addr_t rd_tgt0;
  logic  rd_vld1;
  addr_t rd_tag1;
  addr_t rd_tgt1;

  btb_commit_queue u_queue (
    .rclk(rclk), .rst(rst),
    .commit_takb0(commit_takb0), .commit_pc0(commit_pc0), .commit_tgt0(commit_tgt0),
    .commit_takb1(commit_takb1), .commit_pc1(commit_pc1), .commit_tgt1(commit_tgt1),
    .wr_en(wr_en), .wr_pc(wr_pc), .wr_tgt(wr_tgt)
  );

  btb_table u_table (
    .rclk(rclk), .rst(rst),
    .wr_en(wr_en), .wr_pc(wr_pc), .wr_tgt(wr_tgt),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .rd_valid(rd_valid), .rd_pc(rd_pc),
    .rd_vld0(rd_vld0), .rd_tag0(rd_tag0), .rd_tgt0(rd_tgt0),
    .rd_vld1(rd_vld1), .rd_tag1(rd_tag1), .rd_tgt1(rd_tgt1)
  );

  btb_lookup u_lookup (
    .rclk(rclk), .rst(rst),
    .rd_valid(rd_valid), .rd_pc(rd_pc),
    .rd_vld0(rd_vld0), .rd_tag0(rd_tag0), .rd_tgt0(rd_tgt0),
    .rd_vld1(rd_vld1), .rd_tag1(rd_tag1), .rd_tgt1(rd_tgt1),
    .pred_valid(pred_valid), .next_pc(next_pc), .takb(takb), .takb_slot(takb_slot)
  );

endmodule

`default_nettype wire

// ==== tests/tb_fetch_predict.sv ====
// ==========================================================
// testbench for the two-slot fetch branch predictor
// row table of commits and fetches, reference table model,
// latency and prediction checks, watchdog
// ==========================================================
`default_nettype none

`include "fetch_predict_defines.svh"

module tb_fetch_predict;

  import fetch_predict_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int IN_DLY     = 1;   // drive point after the rising edge
  localparam int RST_CYCLES = 8;
  localparam int DRAIN_IDLE = 10;  // idle cycles after a commit group

  // one stimulus row, either a commit or a fetch
  typedef struct {
    logic  is_fetch;
    logic  takb0;
    addr_t pc0;
    addr_t tgt0;
    logic  takb1;
    addr_t pc1;
    addr_t tgt1;
    addr_t fpc;
  } row_t;

  // expected prediction of one fetch
  typedef struct {
    addr_t pc;
    addr_t next;
    logic  takb;
    logic  slot;
    int    issue;   // last edge before fetch_valid rose
  } exp_t;

  logic  rclk;
  logic  rst;
  logic  commit_takb0;
  addr_t commit_pc0;
  addr_t commit_tgt0;
  logic  commit_takb1;
  addr_t commit_pc1;
  addr_t commit_tgt1;
  logic  fetch_valid;
  addr_t fetch_pc;
  logic  pred_valid;
  addr_t next_pc;
  logic  takb;
  logic  takb_slot;

  row_t  rows [$];
  exp_t  exp_q [$];
  addr_t model_tag [btb_index_t];   // table model, keyed by low index bits
  addr_t model_tgt [btb_index_t];

  int   seed = 29;
  int   edge_cnt = 0;
  int   mismatch_cnt = 0;
  int   other_cnt = 0;
  logic table_ready = 1'b0;

  fetch_predict DUT (
    .rclk(rclk), .rst(rst),
    .commit_takb0(commit_takb0), .commit_pc0(commit_pc0), .commit_tgt0(commit_tgt0),
    .commit_takb1(commit_takb1), .commit_pc1(commit_pc1), .commit_tgt1(commit_tgt1),
    .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
    .pred_valid(pred_valid), .next_pc(next_pc), .takb(takb), .takb_slot(takb_slot)
  );

  initial begin
    rclk = 1'b0;
    forever #(CLK_PERIOD / 2) rclk = ~rclk;
  end

  always @(posedge rclk) edge_cnt <= edge_cnt + 1;   // edges seen so far

  // ==========================================================
  // row builders, unused fields carry random addresses
  // ==========================================================

  function automatic row_t random_row();
    row_t r;
    r.is_fetch = 1'b0;
    r.takb0    = 1'b0;
    r.takb1    = 1'b0;
    r.pc0      = addr_t'($random(seed));
    r.tgt0     = addr_t'($random(seed));
    r.pc1      = addr_t'($random(seed));
    r.tgt1     = addr_t'($random(seed));
    r.fpc      = addr_t'($random(seed));
    return r;
  endfunction

  task automatic single_commit_row(input addr_t pc, input addr_t tgt);
    row_t r;
    r = random_row();
    r.takb0 = 1'b1;
    r.pc0   = pc;
    r.tgt0  = tgt;
    rows.push_back(r);
  endtask

  task automatic dual_commit_row(input addr_t pc0, input addr_t tgt0,
                                 input addr_t pc1, input addr_t tgt1);
    row_t r;
    r = random_row();
    r.takb0 = 1'b1;
    r.pc0   = pc0;
    r.tgt0  = tgt0;
    r.takb1 = 1'b1;   // slot 1 lands behind slot 0
    r.pc1   = pc1;
    r.tgt1  = tgt1;
    rows.push_back(r);
  endtask

  task automatic fetch_row(input addr_t pc);
    row_t r;
    r = random_row();
    r.is_fetch = 1'b1;
    r.fpc      = pc;
    rows.push_back(r);
  endtask

  task automatic build_table();
    int k;
    // empty table, all fall through
    fetch_row(32'h0000_1000);
    fetch_row(32'h0000_40fb);
    fetch_row(32'hffff_fffc);                  // fall-through wraps
    fetch_row(addr_t'($random(seed)));
    // one branch, hit in slot 0 and in slot 1
    single_commit_row(32'h0000_4100, 32'h0000_8000);
    fetch_row(32'h0000_4100);
    fetch_row(32'h0000_40fb);                  // A - 5, branch in slot 1
    // both slots hit, slot 0 wins
    dual_commit_row(32'h0000_5200, 32'h0000_9000, 32'h0000_5205, 32'h0000_a000);
    fetch_row(32'h0000_5200);
    fetch_row(32'h0000_51fb);
    // alias on index 0x100 replaces the entry
    single_commit_row(32'h0000_4500, 32'h0000_b000);
    fetch_row(32'h0000_4100);
    fetch_row(32'h0000_4500);
    fetch_row(32'h0000_40fb);
    // dual commit, distinct and shared index
    dual_commit_row(32'h0000_6000, 32'h0000_c000, 32'h0000_7010, 32'h0000_c100);
    fetch_row(32'h0000_6000);
    fetch_row(32'h0000_7010);
    fetch_row(32'h0000_700b);
    dual_commit_row(32'h0000_8020, 32'h0000_d000, 32'h0000_8420, 32'h0000_d100);
    fetch_row(32'h0000_8020);                  // overwritten by slot 1
    fetch_row(32'h0000_8420);
    fetch_row(32'h0000_841b);
    // burst of four dual commits, then back-to-back fetches
    dual_commit_row(32'h0001_0040, 32'h00a0_0000, 32'h0001_0144, 32'h00a0_0100);
    dual_commit_row(32'h0002_0248, 32'h00a0_0200, 32'h0002_034c, 32'h00a0_0300);
    dual_commit_row(32'h0003_0050, 32'h00a0_0400, 32'h0003_0154, 32'h00a0_0500);
    dual_commit_row(32'h0004_0258, 32'h00a0_0600, 32'h0004_035c, 32'h00a0_0700);
    fetch_row(32'h0001_0040);
    fetch_row(32'h0001_013f);
    fetch_row(32'h0002_0248);
    fetch_row(32'h0002_034c);
    fetch_row(32'h0003_004b);
    fetch_row(32'h0003_0154);
    fetch_row(32'h0004_0258);
    fetch_row(32'h0004_0357);
    fetch_row(32'h0000_4500);
    for (k = 0; k < 6; k++)
      fetch_row(addr_t'($random(seed)));
  endtask

  // ==========================================================
  // reference model
  // ==========================================================

  task automatic model_commit(input addr_t pc, input addr_t tgt);
    btb_index_t idx;
    idx = pc[`FP_INDEX_W-1:0];
    model_tag[idx] = pc;   // later commit replaces
    model_tgt[idx] = tgt;
  endtask

  function automatic exp_t predict(input addr_t pc, input int issue);
    exp_t       e;
    addr_t      s1;
    btb_index_t i0;
    btb_index_t i1;
    s1      = pc + addr_t'(`FP_SLOT_BYTES);
    i0      = pc[`FP_INDEX_W-1:0];
    i1      = s1[`FP_INDEX_W-1:0];
    e.pc    = pc;
    e.issue = issue;
    e.takb  = 1'b0;
    e.slot  = 1'b0;
    e.next  = pc + addr_t'(2 * `FP_SLOT_BYTES);    // fall-through
    if (model_tag.exists(i0) && model_tag[i0] == pc) begin
      e.takb = 1'b1;
      e.next = model_tgt[i0];
    end else if (model_tag.exists(i1) && model_tag[i1] == s1) begin
      e.takb = 1'b1;
      e.slot = 1'b1;
      e.next = model_tgt[i1];
    end
    return e;
  endfunction

  // ==========================================================
  // drive
  // ==========================================================

  task automatic wait_drive_point();
    @(posedge rclk);
    #IN_DLY;
  endtask

  task automatic drive_idle();
    wait_drive_point();
    commit_takb0 = 1'b0;
    commit_takb1 = 1'b0;
    fetch_valid  = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    wait_drive_point();
    commit_takb0 = r.takb0;
    commit_pc0   = r.pc0;
    commit_tgt0  = r.tgt0;
    commit_takb1 = r.takb1;
    commit_pc1   = r.pc1;
    commit_tgt1  = r.tgt1;
    fetch_valid  = r.is_fetch;
    fetch_pc     = r.fpc;
    if (r.is_fetch)
      exp_q.push_back(predict(r.fpc, edge_cnt));   // edges counted from the strobe
    if (r.takb0)
      model_commit(r.pc0, r.tgt0);
    if (r.takb1)
      model_commit(r.pc1, r.tgt1);
  endtask

  // ==========================================================
  // check predictions where outputs are stable
  // ==========================================================

  always @(negedge rclk) begin
    exp_t e;
    if (!rst && pred_valid) begin
      assert (exp_q.size() != 0) else begin
        other_cnt++;
        $display("prediction arrived at %0t with no fetch outstanding", $time);
      end
      if (exp_q.size() != 0) begin
        e = exp_q.pop_front();
        assert (edge_cnt - e.issue == 2) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: fetch %h predicted after %0d edges, expected 2",
                   $time, e.pc, edge_cnt - e.issue);
        end
        assert (takb === e.takb) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: fetch %h takb %b expected %b",
                   $time, e.pc, takb, e.takb);
        end
        assert (next_pc === e.next) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: fetch %h next_pc %h expected %h",
                   $time, e.pc, next_pc, e.next);
        end
        // slot only defined for a taken prediction
        assert (!e.takb || takb_slot === e.slot) else begin
          mismatch_cnt++;
          $display("mismatch at %0t: fetch %h takb_slot %b expected %b",
                   $time, e.pc, takb_slot, e.slot);
        end
      end
    end
  end

  // ==========================================================
  // main sequence
  // ==========================================================

  initial begin
    int i;
    rst          = 1'b1;
    commit_takb0 = 1'b0;
    commit_pc0   = '0;
    commit_tgt0  = '0;
    commit_takb1 = 1'b0;
    commit_pc1   = '0;
    commit_tgt1  = '0;
    fetch_valid  = 1'b0;
    fetch_pc     = '0;
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(posedge rclk);
    #IN_DLY rst = 1'b0;
    for (i = 0; i < rows.size(); i++) begin
      apply_row(rows[i]);
      // end of a commit group, let the queue drain
      if (!rows[i].is_fetch && (i == rows.size() - 1 || rows[i+1].is_fetch))
        repeat (DRAIN_IDLE) drive_idle();
    end
    drive_idle();
    while (exp_q.size() != 0)
      @(posedge rclk);
    repeat (4) drive_idle();   // catch stray predictions
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // watchdog, bound from the row count
  initial begin
    wait (table_ready);
    #((rows.size() * 16 + 200) * CLK_PERIOD);
    other_cnt++;
    $display("timeout, predictions still outstanding: %0d", exp_q.size());
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_predict.f ====
+incdir+verilog
verilog/fetch_predict_pkg.sv
verilog/btb_commit_queue.sv
verilog/btb_table.sv
verilog/btb_lookup.sv
verilog/fetch_predict.sv
tests/tb_fetch_predict.sv

// ==== Bender.yml ====
package:
  name: fetch_predict

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_predict_pkg.sv
      - verilog/btb_commit_queue.sv
      - verilog/btb_table.sv
      - verilog/btb_lookup.sv
      - verilog/fetch_predict.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tb_fetch_predict.sv
